// File: Makefile
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
TOP        := muldiv_tb
RTL_TOP    := muldiv_top
FILELIST   := src.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation passed" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/muldiv_model.svh
`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

localparam u64 RNG_SEED = 64'd92;

// xorshift64, shift triple 13, 7, 17
function automatic u64 xorshift64(input u64 s);
    u64 x;
    x = s ^ (s << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
endfunction

// architectural M result from plain wide arithmetic
function automatic u64 ref_muldiv(input muldiv_op_e op, input logic word,
                                  input u64 a, input u64 b);
    logic signed [129:0] ma;
    logic signed [129:0] mb;
    logic signed [129:0] prod;
    logic                sgn;
    u32                  aw;
    u32                  bw;
    u32                  res_w;
    u64                  res;

    ma   = (op == OP_MULHU) ? {66'd0, a} : {{66{a[63]}}, a};
    mb   = (op inside {OP_MULHSU, OP_MULHU}) ? {66'd0, b} : {{66{b[63]}}, b};
    prod = ma * mb;
    sgn  = op inside {OP_DIV, OP_REM};
    aw   = a[31:0];
    bw   = b[31:0];
    res  = '0;

    if (word) begin
        if (op == OP_MUL) begin
            res_w = aw * bw;
        end else if (bw == '0) begin
            res_w = (op inside {OP_DIV, OP_DIVU}) ? '1 : aw;
        end else if (sgn && aw == 32'h8000_0000 && bw == '1) begin
            res_w = (op == OP_DIV) ? aw : '0;
        end else begin
            case (op)
                OP_DIV:  res_w = $signed(aw) / $signed(bw);
                OP_DIVU: res_w = aw / bw;
                OP_REM:  res_w = $signed(aw) % $signed(bw);
                default: res_w = aw % bw;
            endcase
        end
        res = {{32{res_w[31]}}, res_w};
    end else if (op == OP_MUL) begin
        res = prod[63:0];
    end else if (op inside {OP_MULH, OP_MULHSU, OP_MULHU}) begin
        res = prod[127:64];
    end else if (b == '0) begin
        // quotient all ones, remainder keeps the dividend
        res = (op inside {OP_DIV, OP_DIVU}) ? '1 : a;
    end else if (sgn && a == {1'b1, 63'd0} && b == '1) begin
        res = (op == OP_DIV) ? a : '0;
    end else begin
        case (op)
            OP_DIV:  res = $signed(a) / $signed(b);
            OP_DIVU: res = a / b;
            OP_REM:  res = $signed(a) % $signed(b);
            default: res = a % b;
        endcase
    end
    return res;
endfunction

`endif

// File: sim/muldiv_tb.sv
`include "muldiv_defs.svh"

module muldiv_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import common_pkg::*;
    import muldiv_pkg::*;

    `include "muldiv_model.svh"

    localparam int N_RAND = 10;
    // mul forms, 64-bit divide plus directed signs, word divide, divide by zero, overflow
    localparam int N_TESTS = 5 * N_RAND + 4 * N_RAND + 16 + 4 * N_RAND + 16 + 8;
    localparam int TIMEOUT_CYCLES = N_TESTS * (`DIV_STEPS + 8) + 50;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       new_op;
    muldiv_op_e op;
    logic       word;
    u64         ia;
    u64         ib;
    logic       busy;
    logic       result_valid;
    u64         result;

    // one operation in flight, so one expected entry
    u64   exp_result;
    logic exp_is_mul;

    u64   rng = RNG_SEED;
    u64   last_result = '0;
    logic in_flight = 1'b0;
    int   since_accept = 0;
    int   cycles = 0;
    int   tests_issued = 0;
    int   results_seen = 0;

    muldiv_top muldiv_top_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .new_op       (new_op),
        .op           (op),
        .word         (word),
        .ia           (ia),
        .ib           (ib),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    always #20 clk = ~clk;

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_value(input string name, input u64 expected, input u64 actual);
        $display("[FAIL] t=%0t ns %s expected 0x%h actual 0x%h", $time, name, expected, actual);
        stop_with_failure();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        stop_with_failure();
    endtask

    function automatic u64 next_rand();
        rng = xorshift64(rng);
        return rng;
    endfunction

    task automatic wait_idle();
        while (busy) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic check_idle_outputs();
        assert (!busy) else report_problem("busy is high during or right after reset");
        assert (!result_valid) else report_problem("result_valid is high during reset");
        assert (result === '0) else report_value("result", '0, result);
    endtask

    task automatic run_op(input muldiv_op_e o, input logic w, input u64 a, input u64 b);
        wait_idle();
        op         = o;
        word       = w;
        ia         = a;
        ib         = b;
        exp_result = ref_muldiv(o, w, a, b);
        exp_is_mul = o inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
        new_op     = 1'b1;
        @(posedge clk);
        #2;
        new_op = 1'b0;
        tests_issued++;
    endtask

    task automatic run_div_set(input logic w, input u64 a, input u64 b);
        run_op(OP_DIV, w, a, b);
        run_op(OP_DIVU, w, a, b);
        run_op(OP_REM, w, a, b);
        run_op(OP_REMU, w, a, b);
    endtask

    task automatic mul_tests();
        u64 a;
        u64 b;
        for (int i = 0; i < N_RAND; i++) begin
            a = next_rand();
            b = next_rand();
            run_op(OP_MUL, 1'b0, a, b);
            run_op(OP_MULH, 1'b0, a, b);
            run_op(OP_MULHSU, 1'b0, a, b);
            run_op(OP_MULHU, 1'b0, a, b);
            run_op(OP_MUL, 1'b1, a, b);
        end
    endtask

    task automatic div_tests();
        u64 dvd [4];
        u64 dvs [4];
        u64 a;
        u64 b;
        u64 s;
        // remainder sign must follow the dividend
        dvd = '{-64'd7, -64'd7, 64'd7, -64'd100};
        dvs = '{64'd2, -64'd2, -64'd2, 64'd7};
        for (int i = 0; i < 4; i++) begin
            run_div_set(1'b0, dvd[i], dvs[i]);
        end
        for (int i = 0; i < N_RAND; i++) begin
            a = next_rand();
            s = next_rand();
            b = next_rand() >> s[5:0];
            run_div_set(1'b0, a, b);
        end
    endtask

    task automatic word_div_tests();
        u64 a;
        u64 b;
        u64 s;
        // upper halves stay random
        for (int i = 0; i < N_RAND; i++) begin
            a = next_rand();
            s = next_rand();
            b = next_rand();
            b[31:0] = b[31:0] >> s[4:0];
            run_div_set(1'b1, a, b);
        end
    endtask

    task automatic div_zero_tests();
        u64 a;
        u64 b;
        for (int i = 0; i < 2; i++) begin
            a = next_rand();
            b = next_rand();
            run_div_set(1'b0, a, '0);
            run_div_set(1'b1, a, {b[63:32], 32'h0});
        end
    endtask

    task automatic overflow_tests();
        u64 r;
        for (int i = 0; i < 2; i++) begin
            r = next_rand();
            run_op(OP_DIV, 1'b0, {1'b1, 63'd0}, '1);
            run_op(OP_REM, 1'b0, {1'b1, 63'd0}, '1);
            run_op(OP_DIV, 1'b1, {r[63:32], 32'h8000_0000}, {r[31:0], 32'hFFFF_FFFF});
            run_op(OP_REM, 1'b1, {r[63:32], 32'h8000_0000}, {r[31:0], 32'hFFFF_FFFF});
        end
    endtask

    // compare, latency and control checks on every edge
    always @(posedge clk) begin
        if (arst_n) begin
            since_accept++;
            if (in_flight) begin
                assert (busy) else report_problem("busy dropped before the result arrived");
            end else begin
                assert (!busy) else report_problem("busy is high with nothing in flight");
                assert (!result_valid) else report_problem("result_valid with nothing in flight");
            end
            if (result_valid) begin
                assert (result === exp_result) else report_value("result", exp_result, result);
                if (exp_is_mul) begin
                    assert (since_accept == 4) else report_problem($sformatf(
                        "multiply result came %0d cycles after acceptance, not 4", since_accept));
                end
                last_result = result;
                in_flight = 1'b0;
                results_seen++;
            end else begin
                assert (result === last_result) else report_value("result", last_result, result);
            end
            if (new_op && !busy) begin
                in_flight = 1'b1;
                since_accept = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            report_problem($sformatf("timeout, no result arrived within %0d cycles",
                                     TIMEOUT_CYCLES));
        end
    end

    initial begin
        arst_n     = 1'b0;
        new_op     = 1'b0;
        op         = OP_MUL;
        word       = 1'b0;
        ia         = '0;
        ib         = '0;
        exp_result = '0;
        exp_is_mul = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #2;
            check_idle_outputs();
        end
        arst_n = 1'b1;
        @(posedge clk);
        #2;
        check_idle_outputs();
        mul_tests();
        div_tests();
        word_div_tests();
        div_zero_tests();
        overflow_tests();
        wait_idle();
        if (results_seen == tests_issued && tests_issued == N_TESTS) begin
            $display("Simulation passed");
            $finish;
        end else begin
            report_problem($sformatf("%0d operations issued, %0d results seen, %0d planned",
                                     tests_issued, results_seen, N_TESTS));
        end
    end

endmodule

// File: source/common_pkg.sv
package common_pkg;

    // plain vector types used across the execute stage
    typedef logic [31:0] u32;
    typedef logic [63:0] u64;

    // extended operand, one extra sign bit
    typedef logic [64:0] u65;

    // full width product
    typedef logic [127:0] u128;

endpackage

// File: source/div_unit.sv
`include "muldiv_defs.svh"

module div_unit (
    input  logic           clk,
    input  logic           arst_n,
    muldiv_if.listener     bus,
    output logic           div_done,
    output common_pkg::u64 quotient,
    output common_pkg::u64 remainder
);
    import common_pkg::*;
    import muldiv_pkg::*;

    localparam int CNT_W = $clog2(`DIV_STEPS);

    div_state_e       state;
    logic [CNT_W-1:0] cnt;
    u64               q_reg;
    u64               rem;
    u65               rem_shift;
    logic [65:0]      diff;
    logic             fits;

    // next partial remainder takes the top dividend bit
    assign rem_shift = {rem, q_reg[63]};
    assign diff      = {1'b0, rem_shift} - {2'b00, bus.b_abs};
    assign fits      = !diff[65];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= DIV_IDLE;
            cnt      <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            case (state)
                DIV_IDLE: begin
                    if (bus.start_div) begin
                        state <= DIV_RUN;
                        if (bus.word) begin
                            cnt <= CNT_W'(`DIVW_STEPS - 1);
                        end else begin
                            cnt <= CNT_W'(`DIV_STEPS - 1);
                        end
                    end
                end
                DIV_RUN: begin
                    if (cnt == '0) begin
                        state    <= DIV_DONE;
                        div_done <= 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                DIV_DONE: begin
                    state <= DIV_IDLE;
                end
                default: begin
                    state <= DIV_IDLE;
                end
            endcase
        end
    end

    // q_reg shifts dividend bits out and quotient bits in
    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && bus.start_div) begin
            // word operands start at the top so 32 steps suffice
            if (bus.word) begin
                q_reg <= {bus.a_abs[31:0], 32'h0};
            end else begin
                q_reg <= bus.a_abs;
            end
            rem <= '0;
        end else if (state == DIV_RUN) begin
            q_reg <= {q_reg[62:0], fits};
            if (fits) begin
                rem <= diff[63:0];
            end else begin
                rem <= rem_shift[63:0];
            end
        end
    end

    assign quotient  = q_reg;
    assign remainder = rem;

    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!arst_n) bus.start_div |-> state == DIV_IDLE
    );

    // divisor and width must not move under a running division
    a_operands_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        state == DIV_RUN |-> $stable(bus.b_abs) && $stable(bus.word)
    );

endmodule

// File: source/mul_unit.sv
`include "muldiv_defs.svh"

module mul_unit (
    input  logic            clk,
    input  logic            arst_n,
    muldiv_if.listener      bus,
    output logic            mul_done,
    output common_pkg::u128 mul_product
);
    import common_pkg::*;

    localparam int PP_W = 66;

    logic signed [32:0]     a_lo;
    logic signed [32:0]     a_hi;
    logic signed [32:0]     b_lo;
    logic signed [32:0]     b_hi;
    logic signed [PP_W-1:0] pp_ll;
    logic signed [PP_W-1:0] pp_lh;
    logic signed [PP_W-1:0] pp_hl;
    logic signed [PP_W-1:0] pp_hh;
    logic                   stage1_vld;
    u128                    sum;

    // low halves are unsigned and high halves carry the sign
    assign a_lo = $signed({1'b0, bus.a_ext[31:0]});
    assign a_hi = $signed(bus.a_ext[64:32]);
    assign b_lo = $signed({1'b0, bus.b_ext[31:0]});
    assign b_hi = $signed(bus.b_ext[64:32]);

    // stage one registers the partial products
    always_ff @(posedge clk) begin
        if (bus.start_mul) begin
            pp_ll <= a_lo * b_lo;
            pp_lh <= a_lo * b_hi;
            pp_hl <= a_hi * b_lo;
            pp_hh <= a_hi * b_hi;
        end
    end

    // stage two sign extends and aligns them
    assign sum = {{(`PROD_W - PP_W){pp_ll[PP_W-1]}}, pp_ll}
               + ({{(`PROD_W - PP_W){pp_lh[PP_W-1]}}, pp_lh} << 32)
               + ({{(`PROD_W - PP_W){pp_hl[PP_W-1]}}, pp_hl} << 32)
               + ({{(`PROD_W - PP_W){pp_hh[PP_W-1]}}, pp_hh} << 64);

    always_ff @(posedge clk) begin
        if (stage1_vld) begin
            mul_product <= sum;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage1_vld <= 1'b0;
            mul_done   <= 1'b0;
        end else begin
            stage1_vld <= bus.start_mul;
            mul_done   <= stage1_vld;
        end
    end

    // one product in flight at a time
    a_mul_no_overlap: assert property (
        @(posedge clk) disable iff (!arst_n) bus.start_mul |-> !stage1_vld && !mul_done
    );

endmodule

// File: source/muldiv_defs.svh
`ifndef MULDIV_DEFS_SVH
`define MULDIV_DEFS_SVH

// architectural word width, RV64 only
`define XLEN 64

// full product of two words
`define PROD_W 128

// divider iterations, one quotient bit per cycle
`define DIV_STEPS 64

// word forms only need the low half
`define DIVW_STEPS 32

`endif

// File: source/muldiv_if.sv
interface muldiv_if;
    import common_pkg::*;
    import muldiv_pkg::*;

    // one-cycle start strobes
    logic start_mul;
    logic start_div;

    // held from start until the result is out
    muldiv_op_e op;
    logic       word;
    u65         a_ext;
    u65         b_ext;
    u64         a_abs;
    u64         b_abs;
    logic       neg_q;
    logic       neg_r;
    logic       div_zero;
    logic       overflow;

    modport driver (
        output start_mul, start_div, op, word, a_ext, b_ext,
        output a_abs, b_abs, neg_q, neg_r, div_zero, overflow
    );

    modport listener (
        input start_mul, start_div, op, word, a_ext, b_ext,
        input a_abs, b_abs, neg_q, neg_r, div_zero, overflow
    );

endinterface

// File: source/muldiv_issue.sv
`include "muldiv_defs.svh"

module muldiv_issue (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   new_op,
    input  muldiv_pkg::muldiv_op_e op,
    input  logic                   word,
    input  common_pkg::u64         ia,
    input  common_pkg::u64         ib,
    input  logic                   result_valid,
    output logic                   busy,
    muldiv_if.driver               bus
);
    import common_pkg::*;
    import muldiv_pkg::*;

    localparam u64 MIN_D = {1'b1, {(`XLEN - 1){1'b0}}};
    localparam u64 MIN_W = 64'hFFFF_FFFF_8000_0000;

    logic accept;
    logic a_sgn;
    logic b_sgn;
    logic signed_div;
    logic a_neg;
    logic b_neg;
    u64   a_src;
    u64   b_src;

    assign accept = new_op && !busy;

    // which operands are treated as signed
    always_comb begin
        case (op)
            OP_MUL, OP_MULH, OP_DIV, OP_REM: begin
                a_sgn = 1'b1;
                b_sgn = 1'b1;
            end
            OP_MULHSU: begin
                a_sgn = 1'b1;
                b_sgn = 1'b0;
            end
            default: begin
                a_sgn = 1'b0;
                b_sgn = 1'b0;
            end
        endcase
    end

    assign signed_div = (op == OP_DIV) || (op == OP_REM);

    // word forms take the low half, extended per op
    assign a_src = word ? {{32{a_sgn & ia[31]}}, ia[31:0]} : ia;
    assign b_src = word ? {{32{b_sgn & ib[31]}}, ib[31:0]} : ib;
    assign a_neg = a_sgn && a_src[`XLEN-1];
    assign b_neg = b_sgn && b_src[`XLEN-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy          <= 1'b0;
            bus.start_mul <= 1'b0;
            bus.start_div <= 1'b0;
        end else begin
            bus.start_mul <= accept && !op[2];
            bus.start_div <= accept && op[2];
            if (result_valid) begin
                busy <= 1'b0;
            end else if (accept) begin
                busy <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bus.op    <= op;
            bus.word  <= word;
            bus.a_ext <= {a_neg, a_src};
            bus.b_ext <= {b_neg, b_src};
            bus.a_abs <= a_neg ? -a_src : a_src;
            bus.b_abs <= b_neg ? -b_src : b_src;
            // remainder takes the dividend sign
            bus.neg_q    <= signed_div && (a_neg ^ b_neg);
            bus.neg_r    <= signed_div && a_neg;
            bus.div_zero <= (b_src == '0);
            bus.overflow <= signed_div && (b_src == '1) && (a_src == (word ? MIN_W : MIN_D));
        end
    end

    a_no_issue_while_busy: assert property (
        @(posedge clk) disable iff (!arst_n) busy |-> !new_op
    );

endmodule

// File: source/muldiv_pkg.sv
package muldiv_pkg;

    // values match funct3 of the M extension
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } muldiv_op_e;

    // restoring divider sequencing
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

endpackage

// File: source/muldiv_result.sv
`include "muldiv_defs.svh"

module muldiv_result (
    input  logic            clk,
    input  logic            arst_n,
    muldiv_if.listener      bus,
    input  logic            mul_done,
    input  common_pkg::u128 mul_product,
    input  logic            div_done,
    input  common_pkg::u64  quotient,
    input  common_pkg::u64  remainder,
    output logic            result_valid,
    output common_pkg::u64  result
);
    import common_pkg::*;
    import muldiv_pkg::*;

    u64   mul_sel;
    u64   q_fix;
    u64   r_fix;
    u64   q_out;
    u64   r_out;
    u64   div_sel;
    u64   res_raw;
    u32   res_lo;
    logic is_rem;
    logic done;

    // low word for mul and mulw, high word for the mulh forms
    assign mul_sel = (bus.op == OP_MUL) ? mul_product[`XLEN-1:0]
                                        : mul_product[2*`XLEN-1:`XLEN];

    assign q_fix = bus.neg_q ? -quotient : quotient;
    assign r_fix = bus.neg_r ? -remainder : remainder;

    // architectural special cases override the divider
    always_comb begin
        if (bus.div_zero) begin
            q_out = '1;
            r_out = bus.a_ext[`XLEN-1:0];
        end else if (bus.overflow) begin
            q_out = bus.a_ext[`XLEN-1:0];
            r_out = '0;
        end else begin
            q_out = q_fix;
            r_out = r_fix;
        end
    end

    assign is_rem  = (bus.op == OP_REM) || (bus.op == OP_REMU);
    assign div_sel = is_rem ? r_out : q_out;
    assign res_raw = mul_done ? mul_sel : div_sel;
    assign res_lo  = res_raw[31:0];
    assign done    = mul_done || div_done;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
            result       <= '0;
        end else begin
            result_valid <= done;
            if (done) begin
                result <= bus.word ? {{32{res_lo[31]}}, res_lo} : res_raw;
            end
        end
    end

    // done strobes must agree with the op held on the bus
    a_mul_done_op: assert property (
        @(posedge clk) disable iff (!arst_n) mul_done |-> !bus.op[2] && !div_done
    );

    a_div_done_op: assert property (
        @(posedge clk) disable iff (!arst_n) div_done |-> bus.op[2]
    );

endmodule

// File: source/muldiv_top.sv
module muldiv_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   new_op,
    input  muldiv_pkg::muldiv_op_e op,
    input  logic                   word,
    input  common_pkg::u64         ia,
    input  common_pkg::u64         ib,
    output logic                   busy,
    output logic                   result_valid,
    output common_pkg::u64         result
);
    import common_pkg::*;

    logic mul_done;
    logic div_done;
    u128  mul_product;
    u64   quotient;
    u64   remainder;

    muldiv_if issue_bus ();

    muldiv_issue u_issue (
        .clk          (clk),
        .arst_n       (arst_n),
        .new_op       (new_op),
        .op           (op),
        .word         (word),
        .ia           (ia),
        .ib           (ib),
        .result_valid (result_valid),
        .busy         (busy),
        .bus          (issue_bus)
    );

    mul_unit u_mul (
        .clk         (clk),
        .arst_n      (arst_n),
        .bus         (issue_bus),
        .mul_done    (mul_done),
        .mul_product (mul_product)
    );

    div_unit u_div (
        .clk       (clk),
        .arst_n    (arst_n),
        .bus       (issue_bus),
        .div_done  (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    muldiv_result u_result (
        .clk          (clk),
        .arst_n       (arst_n),
        .bus          (issue_bus),
        .mul_done     (mul_done),
        .mul_product  (mul_product),
        .div_done     (div_done),
        .quotient     (quotient),
        .remainder    (remainder),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

// File: src.f
+incdir+source
+incdir+sim
source/common_pkg.sv
source/muldiv_pkg.sv
source/muldiv_if.sv
source/muldiv_issue.sv
source/mul_unit.sv
source/div_unit.sv
source/muldiv_result.sv
source/muldiv_top.sv
sim/muldiv_tb.sv
